// ==== hw/mf2_pkg.sv ====
/*
 * Shared types and constants for the Multiface Two add-on.
 * Port matches use only the high address byte, as the CPC decodes them.
 * Shadow offsets follow the layout the add-on ROM expects in its RAM.
 */
`default_nettype none

package mf2_pkg;

	//////////////////////////////
	// Widths and basic types
	//////////////////////////////
	localparam int unsigned mf2_addr_w    = 13;
	localparam int unsigned mf2_ram_depth = 2 ** mf2_addr_w;    // 8 KiB

	typedef logic [mf2_addr_w-1:0] ram_addr_t;
	typedef logic [15:0]           cpu_addr_t;
	typedef logic [7:0]            cpu_data_t;

	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t dout;    // CPU write data
		logic      m1;      // Opcode fetch
		logic      io_wr;
		logic      mem_rd;
		logic      mem_wr;
	} cpu_bus_t;

	typedef struct packed {
		logic stop_disabled;    // Button ignored and the add-on never pages in
		logic hide_on_reset;
	} mf2_cfg_t;

	// Gate array command byte with the function in the top two bits
	localparam logic [1:0] ga_func_pen    = 2'b00;
	localparam logic [1:0] ga_func_colour = 2'b01;
	localparam logic [1:0] ga_func_mode   = 2'b10;
	localparam logic [1:0] ga_func_bank   = 2'b11;

	typedef union packed {
		struct packed {
			logic [1:0] func;
			logic       spare;
			logic       border;    // Selects border instead of a pen
			logic [3:0] pen;
		} pen_v;
		struct packed {
			logic [1:0] func;
			logic [5:0] value;
		} colour_v;
	} ga_cmd_u;

	//////////////////////////////
	// Ports and fetch addresses
	//////////////////////////////
	localparam logic [7:0]  port_ga_hi       = 8'h7F;
	localparam logic [7:0]  port_crtc_sel_hi = 8'hBC;
	localparam logic [7:0]  port_crtc_val_hi = 8'hBD;
	localparam logic [7:0]  port_ppi_ctl_hi  = 8'hF7;
	localparam logic [7:0]  port_rom_sel_hi  = 8'hDF;
	localparam logic [13:0] port_mf2_ctl     = 14'b11111110111010;    // FEE8 / FEEA

	localparam cpu_addr_t nmi_vector = 16'h0066;
	localparam cpu_addr_t hide_entry = 16'h0065;

	// Where each write-only register lands in the add-on RAM
	localparam ram_addr_t shadow_pen_idx   = 13'h1FCF;
	localparam ram_addr_t shadow_border    = 13'h1FDF;
	localparam ram_addr_t shadow_pen_base  = 13'h1F90;
	localparam ram_addr_t shadow_mode      = 13'h1FEF;
	localparam ram_addr_t shadow_bank      = 13'h1FFF;
	localparam ram_addr_t shadow_crtc_sel  = 13'h1CFF;
	localparam ram_addr_t shadow_crtc_base = 13'h1DB0;
	localparam ram_addr_t shadow_ppi       = 13'h17FF;
	localparam ram_addr_t shadow_rom_sel   = 13'h1AAC;

	localparam logic [2:0] rom_window = 3'b000;    // 0000-1FFF
	localparam logic [2:0] ram_window = 3'b001;    // 2000-3FFF

	typedef struct packed {
		logic      io_wr_edge;
		logic      m1_edge;
		logic      ctl_port_hit;
		logic      ctl_disable;    // Address bit 1 of the control port
		logic      shadow_hit;
		ram_addr_t shadow_addr;
	} bus_event_t;

	typedef struct packed {
		logic      we;
		ram_addr_t addr;
		cpu_data_t wdata;
	} ram_req_t;

endpackage

`default_nettype wire

// ==== hw/mf2_bus_decode.sv ====
/*
 * Bus decoder for the Multiface Two.
 * Strobe edges are found against the level seen one clock earlier, so
 * io_wr and m1 must stay high for at least one clock per bus cycle.
 * Hit flags are pure address decodes; qualify them with io_wr_edge.
 */
`timescale 1ns/1ns
`default_nettype none

module mf2_bus_decode (
	input  logic                clk_sys,
	input  logic                reset,
	input  mf2_pkg::cpu_bus_t   cpu,
	output mf2_pkg::bus_event_t evt
);

	import mf2_pkg::*;

	logic      io_wr_q;
	logic      m1_q;
	logic      io_wr_edge;
	logic [4:0] pen_sel;     // {border, pen} from the last pen select
	logic [3:0] crtc_reg;    // Last CRTC register select
	logic [7:0] addr_hi;
	ga_cmd_u   cmd;
	logic      is_pen_sel;
	logic      is_colour;
	logic      shadow_hit;
	ram_addr_t shadow_addr;

	assign addr_hi    = cpu.addr[15:8];
	assign cmd        = cpu.dout;
	assign io_wr_edge = cpu.io_wr & ~io_wr_q;

	// Same byte read two ways depending on the function bits
	assign is_pen_sel = cmd.pen_v.func == ga_func_pen;
	assign is_colour  = cmd.colour_v.func == ga_func_colour;

	//////////////////////////////
	// Previous levels and selects
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q  <= 1'b0;
			m1_q     <= 1'b0;
			pen_sel  <= '0;
			crtc_reg <= '0;
		end else begin
			io_wr_q <= cpu.io_wr;
			m1_q    <= cpu.m1;
			if (io_wr_edge && addr_hi == port_ga_hi && is_pen_sel) begin
				pen_sel <= {cmd.pen_v.border, cmd.pen_v.pen};
			end
			if (io_wr_edge && addr_hi == port_crtc_sel_hi) begin
				crtc_reg <= cpu.dout[3:0];
			end
		end
	end

	//////////////////////////////
	// Shadow address map
	//////////////////////////////
	always_comb begin
		shadow_hit  = 1'b1;
		shadow_addr = '0;
		case (addr_hi)
			port_ga_hi: begin
				if (is_pen_sel) begin
					shadow_addr = shadow_pen_idx;
				end else if (is_colour) begin
					// Colour goes to the border or to the selected pen slot
					shadow_addr = pen_sel[4] ? shadow_border
						: shadow_pen_base + ram_addr_t'(pen_sel[3:0]);
				end else if (cmd.pen_v.func == ga_func_mode) begin
					shadow_addr = shadow_mode;
				end else begin
					shadow_addr = shadow_bank;    // RAM banking
				end
			end
			port_crtc_sel_hi: shadow_addr = shadow_crtc_sel;
			port_crtc_val_hi: shadow_addr = shadow_crtc_base + ram_addr_t'(crtc_reg);
			port_ppi_ctl_hi:  shadow_addr = shadow_ppi;        // 8255 control
			port_rom_sel_hi:  shadow_addr = shadow_rom_sel;    // Upper ROM
			default:          shadow_hit  = 1'b0;
		endcase
	end

	assign evt.io_wr_edge   = io_wr_edge;
	assign evt.m1_edge      = cpu.m1 & ~m1_q;
	assign evt.ctl_port_hit = cpu.addr[15:2] == port_mf2_ctl;
	assign evt.ctl_disable  = cpu.addr[1];
	assign evt.shadow_hit   = shadow_hit;
	assign evt.shadow_addr  = shadow_addr;

endmodule

`default_nettype wire

// ==== hw/mf2_paging_ctrl.sv ====
/*
 * Paging controller for the Multiface Two.
 * key_nmi may be asynchronous; it passes one sampling register first.
 * rom_en and ram_en are combinational on the live CPU address.
 * One RAM request per clock; the control port write issues none.
 */
`timescale 1ns/1ns
`default_nettype none

module mf2_paging_ctrl (
	input  logic                clk_sys,
	input  logic                reset,
	input  mf2_pkg::cpu_bus_t   cpu,
	input  mf2_pkg::bus_event_t evt,
	input  logic                key_nmi,
	input  mf2_pkg::mf2_cfg_t   cfg,
	output logic                nmi,
	output logic                mf2_active,
	output logic                rom_en,
	output logic                ram_en,
	output mf2_pkg::ram_req_t   req
);

	import mf2_pkg::*;

	logic      key_s;    // Sampled button
	logic      key_q;
	logic      enable;
	logic      hidden;
	logic      ctl_wr;
	logic      shadow_wr;
	logic      ram_wr;
	logic      req_we;
	ram_addr_t req_addr;
	cpu_data_t req_wdata;

	assign ctl_wr    = evt.io_wr_edge & evt.ctl_port_hit;
	assign shadow_wr = evt.io_wr_edge & evt.shadow_hit & ~ctl_wr;
	assign ram_wr    = cpu.mem_wr & ram_en;

	//////////////////////////////
	// NMI, enable and hidden
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_s  <= 1'b0;
			key_q  <= 1'b0;
			nmi    <= 1'b0;
			enable <= 1'b0;
			hidden <= cfg.hide_on_reset;
			req_we <= 1'b0;
		end else begin
			key_s <= key_nmi;
			key_q <= key_s;
			if (key_s && !key_q && !enable && !cfg.stop_disabled) nmi <= 1'b1;
			if (nmi && evt.m1_edge && cpu.addr == nmi_vector) begin    // Page in
				enable <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end
			if (enable && evt.m1_edge && cpu.addr == hide_entry) hidden <= 1'b1;
			// Port write wins over the paging above
			if (ctl_wr) enable <= ~evt.ctl_disable & ~hidden & ~cfg.stop_disabled;
			req_we <= ~ctl_wr & (shadow_wr | ram_wr);
		end
	end

	// Shadow store takes the decoded offset, everything else the CPU address
	always_ff @(posedge clk_sys) begin
		req_addr  <= shadow_wr ? evt.shadow_addr : ram_addr_t'(cpu.addr[12:0]);
		req_wdata <= cpu.dout;
	end

	assign req.we    = req_we;
	assign req.addr  = req_addr;
	assign req.wdata = req_wdata;

	assign mf2_active = enable;
	assign rom_en     = enable & (cpu.addr[15:13] == rom_window);
	assign ram_en     = enable & (cpu.addr[15:13] == ram_window);

endmodule

`default_nettype wire

// ==== hw/mf2_shadow_ram.sv ====
/*
 * 8 KiB add-on RAM, single port.
 * A write also loads the read register, so the stored byte shows at once.
 * dout idles at FF so it can be ANDed onto a shared read bus.
 */
`timescale 1ns/1ns
`default_nettype none

module mf2_shadow_ram (
	input  logic               clk_sys,
	input  mf2_pkg::ram_req_t  req,
	input  logic               ram_en,
	input  logic               mem_rd,
	output mf2_pkg::cpu_data_t dout
);

	import mf2_pkg::*;

	cpu_data_t mem [mf2_ram_depth];
	cpu_data_t rd_q;

	//////////////////////////////
	// Array and read register
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (req.we) begin
			mem[req.addr] <= req.wdata;
			rd_q          <= req.wdata;    // Write through
		end else begin
			rd_q <= mem[req.addr];
		end
	end

	// Only an enabled read drives the bus low bits
	assign dout = (ram_en & mem_rd) ? rd_q : 8'hFF;

endmodule

`default_nettype wire

// ==== hw/multiface_top.sv ====
/*
 * Multiface Two add-on top level.
 * cpu carries levels straight from the Z80 side; no handshake.
 * dout is FF unless the add-on RAM answers a read.
 */
`timescale 1ns/1ns
`default_nettype none

module multiface_top (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::cpu_bus_t  cpu,
	input  logic               key_nmi,
	input  mf2_pkg::mf2_cfg_t  cfg,
	output logic               nmi,
	output logic               mf2_active,
	output logic               rom_en,
	output logic               ram_en,
	output mf2_pkg::cpu_data_t dout
);

	import mf2_pkg::*;

	bus_event_t evt;
	ram_req_t   req;

	//////////////////////////////
	// Decode
	//////////////////////////////
	mf2_bus_decode u_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu     (cpu),
		.evt     (evt)
	);

	//////////////////////////////
	// Execute
	//////////////////////////////
	mf2_paging_ctrl u_ctrl (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu        (cpu),
		.evt        (evt),
		.key_nmi    (key_nmi),
		.cfg        (cfg),
		.nmi        (nmi),
		.mf2_active (mf2_active),
		.rom_en     (rom_en),
		.ram_en     (ram_en),
		.req        (req)
	);

	//////////////////////////////
	// Result
	//////////////////////////////
	mf2_shadow_ram u_ram (
		.clk_sys (clk_sys),
		.req     (req),
		.ram_en  (ram_en),
		.mem_rd  (cpu.mem_rd),
		.dout    (dout)
	);

endmodule

`default_nettype wire

// ==== test/mf2_properties.sv ====
/*
 * Paging checks bound into every mf2_paging_ctrl.
 * Checks are off while reset is high.
 * fail_count holds the number of failed checks.
 */
`timescale 1ns/1ns
`default_nettype none

module mf2_properties (
	input logic              clk_sys,
	input logic              reset,
	input mf2_pkg::mf2_cfg_t cfg,
	input logic              nmi,
	input logic              enable,
	input logic              mf2_active,
	input logic              rom_en,
	input logic              ram_en
);

	int fail_count = 0;

	//////////////////////////////
	// Paging state
	//////////////////////////////
	// Page in consumes the pending NMI
	nmi_clear_on_enable: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(enable) |-> !nmi)
		else begin
			$error("nmi still pending after the add-on paged in");
			fail_count++;
		end

	windows_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_en && ram_en))
		else begin
			$error("rom_en and ram_en high together");
			fail_count++;
		end

	no_page_when_stopped: assert property (@(posedge clk_sys) disable iff (reset)
		cfg.stop_disabled |-> !$rose(mf2_active))
		else begin
			$error("mf2_active rose with the stop button disabled");
			fail_count++;
		end

endmodule

bind mf2_paging_ctrl mf2_properties u_props (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.cfg        (cfg),
	.nmi        (nmi),
	.enable     (enable),
	.mf2_active (mf2_active),
	.rom_en     (rom_en),
	.ram_en     (ram_en)
);

`default_nettype wire

// ==== test/tb_multiface.sv ====
/*
 * Trace driven testbench for the Multiface Two add-on.
 * Run from the project root since the trace path is relative to it.
 * Inputs change and results are sampled on the falling clock edge.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_multiface;

	import mf2_pkg::*;

	typedef struct packed {
		logic nmi;
		logic active;
		logic rom_en;
		logic ram_en;
	} flags_t;

	localparam int hold_cycles  = 4;     // Each operation keeps its levels this long
	localparam int reset_cycles = 16;
	localparam int settle_limit = 20;

	logic      clk_sys;
	logic      reset;
	cpu_bus_t  cpu;
	logic      key_nmi;
	mf2_cfg_t  cfg;
	logic      nmi;
	logic      mf2_active;
	logic      rom_en;
	logic      ram_en;
	cpu_data_t dout;
	flags_t    flags;

	int data_errs;
	int flag_errs;
	int timeouts;
	int other_errs;

	assign flags = {nmi, mf2_active, rom_en, ram_en};

	multiface_top UUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu        (cpu),
		.key_nmi    (key_nmi),
		.cfg        (cfg),
		.nmi        (nmi),
		.mf2_active (mf2_active),
		.rom_en     (rom_en),
		.ram_en     (ram_en),
		.dout       (dout)
	);

	always #4 clk_sys = ~clk_sys;    // 8 ns period

	//////////////////////////////
	// Helpers and compares
	//////////////////////////////
	task automatic advance_clocks(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic check_data(input string name, input cpu_data_t exp, input cpu_data_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			data_errs++;
		end
	endtask

	task automatic check_flags(input string name, input flags_t exp, input flags_t act);
		if (act !== exp) begin
			$display("ERR %s expected flags %b actual %b", name, exp, act);
			flag_errs++;
		end
	endtask

	task automatic wait_flags(input string name, input flags_t exp);
		int n;
		n = 0;
		while (flags !== exp && n < settle_limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (flags !== exp) begin
			$display("Timeout while waiting for the flags of %s to settle", name);
			timeouts++;
		end
	endtask

	task automatic apply_reset(input mf2_cfg_t c);
		reset   = 1'b1;
		cfg     = c;
		cpu     = '0;
		key_nmi = 1'b0;
		advance_clocks(reset_cycles);
		reset = 1'b0;
	endtask

	// One trace operation checked while its levels are still on the bus
	task automatic run_op(input string op, input cpu_addr_t addr, input cpu_data_t data,
		input logic [7:0] exp_v, input string name);
		cpu      = '0;
		cpu.addr = addr;
		cpu.dout = data;
		if (op == "reset") begin
			apply_reset(mf2_cfg_t'(addr[1:0]));    // cfg rides in the address column
		end else if (op == "press") begin
			key_nmi = 1'b1;
		end else if (op == "fetch") begin
			cpu.m1 = 1'b1;
		end else if (op == "io_write") begin
			cpu.io_wr = 1'b1;
		end else if (op == "mem_write") begin
			cpu.mem_wr = 1'b1;
		end else if (op == "mem_read") begin
			cpu.mem_rd = 1'b1;
		end else begin
			$display("Unknown operation %s in the trace", op);
			other_errs++;
		end
		if (op != "reset") advance_clocks(hold_cycles);
		if (op == "mem_read") begin
			check_data(name, exp_v, dout);
		end else begin
			wait_flags(name, flags_t'(exp_v[3:0]));
			check_flags(name, flags_t'(exp_v[3:0]), flags);
		end
		cpu     = '0;
		key_nmi = 1'b0;
		advance_clocks(1);    // Strobes low for a clock between operations
	endtask

	//////////////////////////////
	// Trace runner
	//////////////////////////////
	initial begin
		int               fd;
		int               code;
		int               op_count;
		int               assert_errs;
		string            op;
		cpu_addr_t        addr;
		cpu_data_t        data;
		logic [7:0]       exp_v;
		logic [8*128-1:0] rest;
		clk_sys    = 1'b0;
		reset      = 1'b1;
		cpu        = '0;
		key_nmi    = 1'b0;
		cfg        = '0;
		data_errs  = 0;
		flag_errs  = 0;
		timeouts   = 0;
		other_errs = 0;
		op_count   = 0;
		apply_reset('0);
		wait_flags("initial reset", '0);
		fd = $fopen("test/mf2_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file test/mf2_trace.txt");
			other_errs++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", op);
				if (code != 1) break;
				if (op == "#") begin
					code = $fgets(rest, fd);    // Skip a comment line
				end else begin
					code = $fscanf(fd, "%h %h %h", addr, data, exp_v);
					if (code != 3) begin
						$display("Malformed trace line after operation %0d", op_count);
						other_errs++;
						break;
					end
					op_count++;
					run_op(op, addr, data, exp_v, $sformatf("%0d:%s@%h", op_count, op, addr));
				end
			end
			$fclose(fd);
			if (op_count == 0) begin
				$display("The trace file holds no operations");
				other_errs++;
			end
		end
		assert_errs = UUT.u_ctrl.u_props.fail_count;
		$display("Errors: data %0d, flags %0d, timeouts %0d, assertions %0d, other %0d",
			data_errs, flag_errs, timeouts, assert_errs, other_errs);
		if (data_errs + flag_errs + timeouts + assert_errs + other_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
hw/mf2_pkg.sv
hw/mf2_bus_decode.sv
hw/mf2_paging_ctrl.sv
hw/mf2_shadow_ram.sv
hw/multiface_top.sv
test/mf2_properties.sv
test/tb_multiface.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert
TOP      = tb_multiface
FILELIST = project.f
OBJDIR   = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== test/mf2_trace.txt ====
# op addr data expect, all hex; reset takes cfg {stop_disabled,hide_on_reset} in addr
# expect is {nmi,mf2_active,rom_en,ram_en}, except for mem_read where it is the byte read
reset     0000 00 0
mem_read  2010 00 ff
mem_read  0066 00 ff
fetch     0066 00 0
press     0000 00 8
fetch     0066 00 6
mem_read  1234 00 ff
mem_write 2010 5a 5
mem_read  2010 00 5a
mem_write 6010 99 4
mem_write 0010 77 6
mem_read  2010 00 5a
io_write  7f00 04 4
io_write  7f00 4b 4
mem_read  3fcf 00 04
mem_read  3f94 00 4b
io_write  7f00 10 4
io_write  7f00 54 4
mem_read  3fdf 00 54
io_write  7f00 8d 4
mem_read  3fef 00 8d
io_write  7f00 c4 4
mem_read  3fff 00 c4
io_write  bc00 0c 4
io_write  bd00 30 4
mem_read  3cff 00 0c
mem_read  3dbc 00 30
io_write  f700 82 4
mem_read  37ff 00 82
io_write  df00 07 4
mem_read  3aac 00 07
io_write  feea 00 0
mem_read  3f94 00 ff
io_write  fee8 00 4
mem_read  3f94 00 4b
fetch     0065 00 6
io_write  feea 00 0
io_write  fee8 00 0
press     0000 00 8
fetch     0066 00 6
reset     0002 00 0
press     0000 00 0
fetch     0066 00 0
mem_read  2010 00 ff
reset     0001 00 0
press     0000 00 8
fetch     0066 00 6
io_write  fee8 00 4
